// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int DataWidth = 8;
	localparam int AddrWidth = 16;

	localparam logic [AddrWidth-1:0] ResetPc = 16'h0200;

	// documented mnemonics first, then the undocumented ones
	typedef enum logic [7:0] {
		ADC, AND, ASL, BCC, BCS, BEQ, BIT, BMI,
		BNE, BPL, BRK, BVC, BVS, CLC, CLD, CLI,
		CLV, CMP, CPX, CPY, DEC, DEX, DEY, EOR,
		INC, INX, INY, JMP, JSR, LDA, LDX, LDY,
		LSR, NOP, ORA, PHA, PHP, PLA, PLP, ROL,
		ROR, RTI, RTS, SBC, SEC, SED, SEI, STA,
		STX, STY, TAX, TAY, TSX, TXA, TXS, TYA,
		AHX, ALR, ANC, ARR, AXS, DCP, ISC, KIL,
		LAS, LAX, RLA, RRA, SAX, SHX, SHY, SLO,
		SRE, TAS, XAA
	} Opcode;

	typedef enum logic [3:0] {
		Imp,	// implied or accumulator
		Imm,
		Ind,	// JMP only
		IndX,
		IndY,
		Zpg,
		ZpgX,
		ZpgY,
		Abs,
		AbsX,
		AbsY,
		Rlt	// branch offset
	} Addressing;

	typedef struct packed {
		logic [DataWidth-1:0] hi;
		logic [DataWidth-1:0] lo;
	} BytePair;

	// operand bytes as fetched, hi stays zero for short instructions
	typedef union packed {
		logic [AddrWidth-1:0] addr;
		BytePair pair;
	} OperandWord;

endpackage

`default_nettype wire

// File: common/instrIf.sv
`timescale 1ns/10ps
`default_nettype none

interface instrIf import cpuPkg::*; ();

	logic valid;	// one cycle per record
	Opcode opcode;
	Addressing mode;
	logic [1:0] length;
	logic [AddrWidth-1:0] pc;
	OperandWord operand;
	logic [AddrWidth-1:0] target;

	modport src (
		output valid,
		output opcode,
		output mode,
		output length,
		output pc,
		output operand,
		output target
	);

	modport dst (
		input valid,
		input opcode,
		input mode,
		input length,
		input pc,
		input operand,
		input target
	);

endinterface

`default_nettype wire

// File: fetch/idec.sv
`timescale 1ns/10ps
`default_nettype none

module idec import cpuPkg::*; (
	input logic [DataWidth-1:0] ins,
	output Opcode opcode,
	output Addressing mode,
	output logic [1:0] pcBytes
);

	Opcode lutOp[256];
	Addressing lutMode[256];
	logic [1:0] len;

	// one row per high nibble
	assign lutOp = '{
		BRK,	ORA,	KIL,	SLO,	NOP,	ORA,	ASL,	SLO,	PHP,	ORA,	ASL,	ANC,	NOP,	ORA,	ASL,	SLO,	// 0x
		BPL,	ORA,	KIL,	SLO,	NOP,	ORA,	ASL,	SLO,	CLC,	ORA,	NOP,	SLO,	NOP,	ORA,	ASL,	SLO,	// 1x
		JSR,	AND,	KIL,	RLA,	BIT,	AND,	ROL,	RLA,	PLP,	AND,	ROL,	ANC,	BIT,	AND,	ROL,	RLA,	// 2x
		BMI,	AND,	KIL,	RLA,	NOP,	AND,	ROL,	RLA,	SEC,	AND,	NOP,	RLA,	NOP,	AND,	ROL,	RLA,	// 3x
		RTI,	EOR,	KIL,	SRE,	NOP,	EOR,	LSR,	SRE,	PHA,	EOR,	LSR,	ALR,	JMP,	EOR,	LSR,	SRE,	// 4x
		BVC,	EOR,	KIL,	SRE,	NOP,	EOR,	LSR,	SRE,	CLI,	EOR,	NOP,	SRE,	NOP,	EOR,	LSR,	SRE,	// 5x
		RTS,	ADC,	KIL,	RRA,	NOP,	ADC,	ROR,	RRA,	PLA,	ADC,	ROR,	ARR,	JMP,	ADC,	ROR,	RRA,	// 6x
		BVS,	ADC,	KIL,	RRA,	NOP,	ADC,	ROR,	RRA,	SEI,	ADC,	NOP,	RRA,	NOP,	ADC,	ROR,	RRA,	// 7x
		NOP,	STA,	NOP,	SAX,	STY,	STA,	STX,	SAX,	DEY,	NOP,	TXA,	XAA,	STY,	STA,	STX,	SAX,	// 8x
		BCC,	STA,	KIL,	AHX,	STY,	STA,	STX,	SAX,	TYA,	STA,	TXS,	TAS,	SHY,	STA,	SHX,	AHX,	// 9x
		LDY,	LDA,	LDX,	LAX,	LDY,	LDA,	LDX,	LAX,	TAY,	LDA,	TAX,	LAX,	LDY,	LDA,	LDX,	LAX,	// ax
		BCS,	LDA,	KIL,	LAX,	LDY,	LDA,	LDX,	LAX,	CLV,	LDA,	TSX,	LAS,	LDY,	LDA,	LDX,	LAX,	// bx
		CPY,	CMP,	NOP,	DCP,	CPY,	CMP,	DEC,	DCP,	INY,	CMP,	DEX,	AXS,	CPY,	CMP,	DEC,	DCP,	// cx
		BNE,	CMP,	KIL,	DCP,	NOP,	CMP,	DEC,	DCP,	CLD,	CMP,	NOP,	DCP,	NOP,	CMP,	DEC,	DCP,	// dx
		CPX,	SBC,	NOP,	ISC,	CPX,	SBC,	INC,	ISC,	INX,	SBC,	NOP,	SBC,	CPX,	SBC,	INC,	ISC,	// ex
		BEQ,	SBC,	KIL,	ISC,	NOP,	SBC,	INC,	ISC,	SED,	SBC,	NOP,	ISC,	NOP,	SBC,	INC,	ISC	// fx
	};

	assign lutMode = '{
		Imp,	IndX,	Imp,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// 0x
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgX,	ZpgX,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsX,	AbsX,	// 1x
		Abs,	IndX,	Imp,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// 2x
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgX,	ZpgX,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsX,	AbsX,	// 3x
		Imp,	IndX,	Imp,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// 4x
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgX,	ZpgX,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsX,	AbsX,	// 5x
		Imp,	IndX,	Imp,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Ind,	Abs,	Abs,	Abs,	// 6x
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgX,	ZpgX,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsX,	AbsX,	// 7x
		Imm,	IndX,	Imm,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// 8x
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgY,	ZpgY,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsY,	AbsY,	// 9x
		Imm,	IndX,	Imm,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// ax
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgY,	ZpgY,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsY,	AbsY,	// bx
		Imm,	IndX,	Imm,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// cx
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgX,	ZpgX,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsX,	AbsX,	// dx
		Imm,	IndX,	Imm,	IndX,	Zpg,	Zpg,	Zpg,	Zpg,	Imp,	Imm,	Imp,	Imm,	Abs,	Abs,	Abs,	Abs,	// ex
		Rlt,	IndY,	Imp,	IndY,	ZpgX,	ZpgX,	ZpgX,	ZpgX,	Imp,	AbsY,	Imp,	AbsY,	AbsX,	AbsX,	AbsX,	AbsX	// fx
	};

	assign opcode = lutOp[ins];
	assign mode = lutMode[ins];
	assign pcBytes = len;

	always_comb
	begin
		len = 2'd1;
		case (mode)
			Imp:
				len = 2'd1;
			Imm, IndX, IndY, Zpg, ZpgX, ZpgY, Rlt:
				len = 2'd2;	// one operand byte
			Ind, Abs, AbsX, AbsY:
				len = 2'd3;	// full address
			default:
				len = 2'd1;
		endcase
	end

endmodule

`default_nettype wire

// File: fetch/instrAssembler.sv
`timescale 1ns/10ps
`default_nettype none

module instrAssembler import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic byteValid,
	input logic [DataWidth-1:0] byteData,
	input logic haltIn,
	instrIf.src out
);

	logic [DataWidth-1:0] opByte;
	logic [1:0] have;	// bytes collected so far, 0 when idle
	logic [AddrWidth-1:0] pc;
	OperandWord operand;
	Opcode opc;
	Addressing md;
	logic [1:0] len;
	logic done;
	logic take;
	logic isOpcode;

	idec dec (
		.ins(opByte),
		.opcode(opc),
		.mode(md),
		.pcBytes(len)
	);

	assign done = (have != 2'd0) && (have == len);
	assign take = byteValid && !haltIn;
	assign isOpcode = (have == 2'd0) || done;	// next byte starts a new instruction

	assign out.target = '0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			have <= 2'd0;
			pc <= ResetPc;
			out.valid <= 1'b0;
		end
		else
		begin
			out.valid <= done;
			if (done)
				pc <= pc + AddrWidth'(len);
			if (take)
				have <= isOpcode ? 2'd1 : have + 2'd1;
			else if (done)
				have <= 2'd0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			opByte <= '0;
			operand <= '0;
		end
		else if (take)
		begin
			if (isOpcode)
			begin
				opByte <= byteData;
				operand <= '0;
			end
			else if (have == 2'd1)
				operand.pair.lo <= byteData;	// little endian
			else
				operand.pair.hi <= byteData;
		end
		if (done)
		begin
			out.opcode <= opc;
			out.mode <= md;
			out.length <= len;
			out.pc <= pc;
			out.operand <= operand;
		end
	end

	// operand bytes never run past the decoded length
	assert property (@(posedge clk) disable iff (rst)
		have != 2'd0 |-> have <= len);

endmodule

`default_nettype wire

// File: decode/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import cpuPkg::*; (
	input logic clk,
	input logic rst,
	instrIf.dst in,
	instrIf.src out
);

	logic [AddrWidth-1:0] seqPc;
	logic [AddrWidth-1:0] branchPc;
	logic [AddrWidth-1:0] target;
	logic isJump;

	assign seqPc = in.pc + AddrWidth'(in.length);
	assign branchPc = in.pc + 16'd2
		+ {{(AddrWidth - DataWidth){in.operand.pair.lo[DataWidth-1]}}, in.operand.pair.lo};

	// JMP (ind) resolves to the pointer, not the final address
	assign isJump = ((in.opcode == JMP || in.opcode == JSR) && in.mode == Abs)
		|| (in.opcode == JMP && in.mode == Ind);

	always_comb
	begin
		if (in.mode == Rlt)
			target = branchPc;
		else if (isJump)
			target = in.operand.addr;
		else
			target = seqPc;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	always_ff @(posedge clk)
	begin
		if (in.valid)
		begin
			out.opcode <= in.opcode;
			out.mode <= in.mode;
			out.length <= in.length;
			out.pc <= in.pc;
			out.operand <= in.operand;
			out.target <= target;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		in.valid |-> in.length != 2'd0);

endmodule

`default_nettype wire

// File: logic/issueStage.sv
`timescale 1ns/10ps
`default_nettype none

module issueStage import cpuPkg::*; (
	input logic clk,
	input logic rst,
	instrIf.dst in,
	output logic outValid,
	output Opcode outOpcode,
	output Addressing outMode,
	output logic [1:0] outLength,
	output logic [AddrWidth-1:0] outPc,
	output OperandWord outOperand,
	output logic [AddrWidth-1:0] outTarget,
	output logic halted
);

	logic accept;

	assign accept = in.valid && !halted;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			halted <= 1'b0;
		end
		else
		begin
			outValid <= accept;
			if (accept && in.opcode == KIL)
				halted <= 1'b1;	// jam, held until reset
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			outOpcode <= in.opcode;
			outMode <= in.mode;
			outLength <= in.length;
			outPc <= in.pc;
			outOperand <= in.operand;
			outTarget <= in.target;
		end
	end

	// nothing issues once the front end has jammed
	assert property (@(posedge clk) disable iff (rst)
		halted |=> !outValid);

endmodule

`default_nettype wire

// File: logic/fetchDecodeTop.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecodeTop import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic byteValid,
	input logic [DataWidth-1:0] byteData,
	output logic outValid,
	output Opcode outOpcode,
	output Addressing outMode,
	output logic [1:0] outLength,
	output logic [AddrWidth-1:0] outPc,
	output OperandWord outOperand,
	output logic [AddrWidth-1:0] outTarget,
	output logic halted
);

	instrIf asmBus ();
	instrIf decBus ();

	instrAssembler assembler (
		.clk(clk),
		.rst(rst),
		.byteValid(byteValid),
		.byteData(byteData),
		.haltIn(halted),	// stop taking bytes after KIL
		.out(asmBus.src)
	);

	decodeStage decode (
		.clk(clk),
		.rst(rst),
		.in(asmBus.dst),
		.out(decBus.src)
	);

	issueStage issue (
		.clk(clk),
		.rst(rst),
		.in(decBus.dst),
		.outValid(outValid),
		.outOpcode(outOpcode),
		.outMode(outMode),
		.outLength(outLength),
		.outPc(outPc),
		.outOperand(outOperand),
		.outTarget(outTarget),
		.halted(halted)
	);

endmodule

`default_nettype wire

// File: dv/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// jam opcodes sit in column 2 of rows 0-7 and in the odd rows of 9-f
function automatic bit isKil(input logic [7:0] op);
	return op[1:0] == 2'b10 && ((op[4:2] == 3'd0 && !op[7]) || op[4:2] == 3'd4);
endfunction

// mode from the aaabbbcc opcode layout
function automatic Addressing refMode(input logic [7:0] op);
	logic [2:0] aaa;
	logic [2:0] bbb;
	logic yRow;
	Addressing m;
	aaa = op[7:5];
	bbb = op[4:2];
	yRow = aaa[2:1] == 2'b10;	// store/load rows index with Y
	m = Imp;
	if (op[0])
	begin
		case (bbb)
			3'd0: m = IndX;
			3'd1: m = Zpg;
			3'd2: m = Imm;
			3'd3: m = Abs;
			3'd4: m = IndY;
			3'd5: m = (op[1] && yRow) ? ZpgY : ZpgX;
			3'd6: m = AbsY;
			default: m = (op[1] && yRow) ? AbsY : AbsX;
		endcase
	end
	else if (op[1])
	begin
		case (bbb)
			3'd0: m = aaa[2] ? Imm : Imp;
			3'd1: m = Zpg;
			3'd3: m = Abs;
			3'd5: m = yRow ? ZpgY : ZpgX;
			3'd7: m = yRow ? AbsY : AbsX;
			default: m = Imp;
		endcase
	end
	else
	begin
		case (bbb)
			3'd0: m = (aaa == 3'd1) ? Abs : (aaa[2] ? Imm : Imp);	// JSR abs
			3'd1: m = Zpg;
			3'd3: m = (aaa == 3'd3) ? Ind : Abs;
			3'd4: m = Rlt;
			3'd5: m = ZpgX;
			3'd7: m = AbsX;
			default: m = Imp;
		endcase
	end
	return m;
endfunction

function automatic logic [1:0] refLength(input Addressing m);
	if (m == Imp)
		return 2'd1;
	if (m == Ind || m == Abs || m == AbsX || m == AbsY)
		return 2'd3;
	return 2'd2;
endfunction

// only the classes worth pinning down, returns 0 otherwise
function automatic bit refOpcode(input logic [7:0] op, output Opcode mn);
	Opcode branches[8];
	Opcode alu[8];
	branches = '{BPL, BMI, BVC, BVS, BCC, BCS, BNE, BEQ};
	alu = '{ORA, AND, EOR, ADC, STA, LDA, CMP, SBC};
	mn = NOP;
	if (isKil(op))
		mn = KIL;
	else if (op == 8'h4C || op == 8'h6C)
		mn = JMP;
	else if (op == 8'h20)
		mn = JSR;
	else if (op[4:0] == 5'b10000)
		mn = branches[op[7:5]];
	else if (op[1:0] == 2'b01 && op != 8'h89)
		mn = alu[op[7:5]];
	else
		return 1'b0;
	return 1'b1;
endfunction

function automatic logic [15:0] refTarget(input logic [15:0] pc, input logic [7:0] op,
	input OperandWord w);
	Addressing m;
	m = refMode(op);
	if (m == Rlt)
		return pc + 16'd2 + {{8{w.pair.lo[7]}}, w.pair.lo};
	if (op == 8'h4C || op == 8'h6C || op == 8'h20)
		return w.addr;	// pointer address for JMP (ind)
	return pc + 16'(refLength(m));
endfunction

`endif

// File: dv/fdTb.sv
`timescale 1ns/10ps
`default_nettype none

module fdTb import cpuPkg::*; ();

	`include "refModel.svh"

	typedef struct {
		logic [7:0] op;
		bit opKnown;
		Opcode opcode;
		Addressing mode;
		logic [1:0] length;
		logic [AddrWidth-1:0] pc;
		OperandWord operand;
		logic [AddrWidth-1:0] target;
		bit kil;
		int due;	// cycle count when outValid is due
	} ExpRec;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic byteValid = 1'b0;
	logic [DataWidth-1:0] byteData = '0;
	logic outValid;
	Opcode outOpcode;
	Addressing outMode;
	logic [1:0] outLength;
	logic [AddrWidth-1:0] outPc;
	OperandWord outOperand;
	logic [AddrWidth-1:0] outTarget;
	logic halted;

	ExpRec expq[$];
	ExpRec got;
	logic [AddrWidth-1:0] pcModel = ResetPc;
	int cycles = 0;
	int driveCycles = 0;
	string testName = "reset";
	logic [7:0] op;
	int i;

	fetchDecodeTop DUT (
		.clk(clk),
		.rst(rst),
		.byteValid(byteValid),
		.byteData(byteData),
		.outValid(outValid),
		.outOpcode(outOpcode),
		.outMode(outMode),
		.outLength(outLength),
		.outPc(outPc),
		.outOperand(outOperand),
		.outTarget(outTarget),
		.halted(halted)
	);

	always #4 clk = ~clk;

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkOpcode(input Opcode exp, input Opcode act);
		if (exp !== act)
			failRun($sformatf("ERROR %s opcode: expected %s actual %s", testName,
				exp.name(), act.name()));
	endtask

	task automatic checkMode(input Addressing exp, input Addressing act);
		if (exp !== act)
			failRun($sformatf("ERROR %s mode: expected %s actual %s", testName,
				exp.name(), act.name()));
	endtask

	task automatic checkWord(input string what, input logic [AddrWidth-1:0] exp,
		input logic [AddrWidth-1:0] act);
		if (exp !== act)
			failRun($sformatf("ERROR %s %s: expected %04h actual %04h", testName, what, exp, act));
	endtask

	task automatic checkLength(input logic [1:0] exp, input logic [1:0] act);
		if (exp !== act)
			failRun($sformatf("ERROR %s length: expected %0d actual %0d", testName, exp, act));
	endtask

	task automatic checkFlag(input string what, input logic exp, input logic act);
		if (exp !== act)
			failRun($sformatf("ERROR %s %s: expected %b actual %b", testName, what, exp, act));
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			byteValid = 1'b0;
			@(posedge clk);
			#1;
			driveCycles++;
		end
	endtask

	task automatic applyReset();
		rst = 1'b1;
		byteValid = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		driveCycles += 4;
		pcModel = ResetPc;
	endtask

	task automatic sendInstr(input logic [7:0] opc, input logic [7:0] lo, input logic [7:0] hi,
		input int gapMax, input bit keep);
		ExpRec r;
		logic [7:0] bytes[3];
		int k;
		r.op = opc;
		r.opKnown = refOpcode(opc, r.opcode);
		r.mode = refMode(opc);
		r.length = refLength(r.mode);
		r.pc = pcModel;
		r.operand.addr = '0;
		if (r.length >= 2'd2)
			r.operand.pair.lo = lo;
		if (r.length == 2'd3)
			r.operand.pair.hi = hi;
		r.target = refTarget(pcModel, opc, r.operand);
		r.kil = isKil(opc);
		bytes = '{opc, lo, hi};
		for (k = 0; k < int'(r.length); k++)
		begin
			byteValid = 1'b1;
			byteData = bytes[k];
			if (k == int'(r.length) - 1)
			begin
				r.due = cycles + 4;	// sampled next edge, out three edges later
				if (keep)
					expq.push_back(r);
			end
			@(posedge clk);
			#1;
			byteValid = 1'b0;
			driveCycles++;
			idle(gapMax > 0 ? int'($urandom_range(gapMax, 0)) : 0);
		end
		pcModel = pcModel + 16'(r.length);
	endtask

	task automatic drain();
		while (expq.size() != 0)
			@(posedge clk);
		#1;
	endtask

	function automatic logic [7:0] pickShort();
		logic [7:0] b;
		b = 8'($urandom());
		while (refLength(refMode(b)) != 2'd1 || isKil(b))
			b = 8'($urandom());
		return b;
	endfunction

	function automatic logic [7:0] pickAny();
		logic [7:0] b;
		b = 8'($urandom());
		while (isKil(b))
			b = 8'($urandom());
		return b;
	endfunction

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > 2 * driveCycles + 100)
			failRun($sformatf("timeout in %s after %0d cycles", testName, cycles));
	end

	always @(negedge clk)
	begin
		if (!rst && outValid === 1'b1)
		begin
			if (expq.size() == 0)
				failRun($sformatf("%s: outValid pulsed with no instruction outstanding", testName));
			else
			begin
				got = expq.pop_front();
				if (got.opKnown)
					checkOpcode(got.opcode, outOpcode);
				checkMode(got.mode, outMode);
				checkLength(got.length, outLength);
				checkWord("pc", got.pc, outPc);
				checkWord("operand", got.operand.addr, outOperand.addr);
				checkWord("target", got.target, outTarget);
				checkFlag("halted", got.kil, halted);	// rises with the KIL record
				if (cycles != got.due)
					failRun($sformatf("ERROR %s latency of %02h: expected cycle %0d actual cycle %0d",
						testName, got.op, got.due, cycles));
			end
		end
		else if (!rst && expq.size() != 0 && cycles > expq[0].due)
			failRun($sformatf("%s: instruction %02h at pc %04h never came out", testName,
				expq[0].op, expq[0].pc));
	end

	initial
	begin
		void'($urandom(42));
		applyReset();

		testName = "lengths";
		for (i = 0; i < 256; i++)
			if (!isKil(8'(i)))
				sendInstr(8'(i), 8'($urandom()), 8'($urandom()), 0, 1'b1);
		sendInstr(8'h02, 8'h00, 8'h00, 0, 1'b1);	// jams, so it goes last
		drain();
		applyReset();

		testName = "branches";
		for (i = 0; i < 16; i++)
		begin
			op = {3'(i), 5'b10000};
			sendInstr(op, i < 8 ? 8'($urandom_range(127, 0)) : 8'($urandom_range(255, 128)),
				8'h00, 1, 1'b1);
		end
		drain();

		testName = "jumps";
		for (i = 0; i < 9; i++)
		begin
			op = (i % 3 == 0) ? 8'h4C : ((i % 3 == 1) ? 8'h6C : 8'h20);
			sendInstr(op, 8'($urandom()), 8'($urandom()), 0, 1'b1);
		end
		drain();

		testName = "backToBack";
		for (i = 0; i < 24; i++)
			sendInstr(pickShort(), 8'h00, 8'h00, 0, 1'b1);
		drain();

		testName = "gapped";
		for (i = 0; i < 40; i++)
			sendInstr(pickAny(), 8'($urandom()), 8'($urandom()), 3, 1'b1);
		drain();

		testName = "kilHalt";
		for (i = 0; i < 256; i++)
			if (isKil(8'(i)))
			begin
				applyReset();
				checkFlag("halted after reset", 1'b0, halted);
				sendInstr(8'h4C, 8'($urandom()), 8'($urandom()), 0, 1'b1);	// pc restarts
				sendInstr(8'(i), 8'h00, 8'h00, 0, 1'b1);
				repeat (3) sendInstr(pickAny(), 8'($urandom()), 8'($urandom()), 0, 1'b0);
				drain();
				idle(10);
				checkFlag("halted held", 1'b1, halted);
			end

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
common/cpuPkg.sv
common/instrIf.sv
fetch/idec.sv
fetch/instrAssembler.sv
decode/decodeStage.sv
logic/issueStage.sv
logic/fetchDecodeTop.sv
dv/fdTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= fdTb
RTL_TOP ?= fetchDecodeTop
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/10ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

SRCS := $(shell grep -v '^+' $(FILELIST)) dv/refModel.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
